//--- design/id_pkg.sv
package id_pkg;

    localparam int XLEN   = 32;
    localparam int NREG   = 32;
    localparam int REG_AW = $clog2(NREG);

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]   word_t;

    // instruction field positions
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int I12_LSB  = 10;
    localparam int I16_LSB  = 10;
    localparam int I20_LSB  = 5;
    localparam int OP10_LSB = 22;
    localparam int OP17_LSB = 15;

    // inst[31:26]
    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    // inst[31:25]
    localparam logic [6:0] OP7_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP7_PCADDU12I = 7'h0e;

    // inst[31:22]
    localparam logic [9:0] OP10_3R     = 10'h000;
    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_SLTUI  = 10'h009;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_XORI   = 10'h00f;
    localparam logic [9:0] OP10_LD_B   = 10'h0a0;
    localparam logic [9:0] OP10_LD_H   = 10'h0a1;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_B   = 10'h0a4;
    localparam logic [9:0] OP10_ST_H   = 10'h0a5;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;
    localparam logic [9:0] OP10_LD_BU  = 10'h0a8;
    localparam logic [9:0] OP10_LD_HU  = 10'h0a9;

    // inst[31:15]
    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_NOR    = 17'h00028;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_XOR    = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP17_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP17_SRA_W  = 17'h00030;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_H, MEM_LD_W, MEM_LD_BU, MEM_LD_HU,
        MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_B, BR_BL, BR_JIRL
    } branch_e;

    typedef enum logic [2:0] {
        IMM_FOUR, IMM_SI20_HI, IMM_SI12, IMM_UI5, IMM_UI12
    } imm_sel_e;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_bypass_t;

    typedef struct packed {
        logic       is_load;
        rf_bypass_t rf;
    } ex_bypass_t;

    typedef struct packed {
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        branch_e   branch;
        imm_sel_e  imm_sel;
        word_t     imm;
        word_t     br_offs;
        reg_addr_t rj;
        reg_addr_t rkd;
        logic      need_r1;
        logic      need_r2;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } decode_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     pc;
        mem_op_e   mem_op;
        word_t     store_data;
    } id_to_ex_t;

endpackage

//--- design/id_decoder.sv
`timescale 1ns/10ps

module id_decoder
    import id_pkg::*;
(
    input  word_t   i_inst,
    output decode_t o_dec
);

    alu_op_e     alu_op;
    mem_op_e     mem_op;
    branch_e     branch;
    imm_sel_e    imm_sel;
    word_t       imm;
    logic        known;
    logic        reg_reg;
    logic        is_store;
    logic        is_cond;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign rd  = i_inst[RD_LSB +: REG_AW];
    assign rj  = i_inst[RJ_LSB +: REG_AW];
    assign rk  = i_inst[RK_LSB +: REG_AW];
    assign i12 = i_inst[I12_LSB +: 12];
    assign i16 = i_inst[I16_LSB +: 16];
    assign i20 = i_inst[I20_LSB +: 20];
    // upper offset bits live in the rd/rj slots
    assign i26 = {i_inst[RD_LSB +: 10], i16};

    always_comb begin
        alu_op  = ALU_ADD;
        mem_op  = MEM_NONE;
        branch  = BR_NONE;
        imm_sel = IMM_SI12;
        known   = 1'b1;
        casez (i_inst[31:OP17_LSB])
            OP17_ADD_W:  alu_op = ALU_ADD;
            OP17_SUB_W:  alu_op = ALU_SUB;
            OP17_SLT:    alu_op = ALU_SLT;
            OP17_SLTU:   alu_op = ALU_SLTU;
            OP17_NOR:    alu_op = ALU_NOR;
            OP17_AND:    alu_op = ALU_AND;
            OP17_OR:     alu_op = ALU_OR;
            OP17_XOR:    alu_op = ALU_XOR;
            OP17_SLL_W:  alu_op = ALU_SLL;
            OP17_SRL_W:  alu_op = ALU_SRL;
            OP17_SRA_W:  alu_op = ALU_SRA;
            OP17_SLLI_W: begin
                alu_op  = ALU_SLL;
                imm_sel = IMM_UI5;
            end
            OP17_SRLI_W: begin
                alu_op  = ALU_SRL;
                imm_sel = IMM_UI5;
            end
            OP17_SRAI_W: begin
                alu_op  = ALU_SRA;
                imm_sel = IMM_UI5;
            end
            {OP10_SLTI, 7'b?}:   alu_op = ALU_SLT;
            {OP10_SLTUI, 7'b?}:  alu_op = ALU_SLTU;
            {OP10_ADDI_W, 7'b?}: alu_op = ALU_ADD;
            {OP10_ANDI, 7'b?}: begin
                alu_op  = ALU_AND;
                imm_sel = IMM_UI12;
            end
            {OP10_ORI, 7'b?}: begin
                alu_op  = ALU_OR;
                imm_sel = IMM_UI12;
            end
            {OP10_XORI, 7'b?}: begin
                alu_op  = ALU_XOR;
                imm_sel = IMM_UI12;
            end
            {OP10_LD_B, 7'b?}:  mem_op = MEM_LD_B;
            {OP10_LD_H, 7'b?}:  mem_op = MEM_LD_H;
            {OP10_LD_W, 7'b?}:  mem_op = MEM_LD_W;
            {OP10_LD_BU, 7'b?}: mem_op = MEM_LD_BU;
            {OP10_LD_HU, 7'b?}: mem_op = MEM_LD_HU;
            {OP10_ST_B, 7'b?}:  mem_op = MEM_ST_B;
            {OP10_ST_H, 7'b?}:  mem_op = MEM_ST_H;
            {OP10_ST_W, 7'b?}:  mem_op = MEM_ST_W;
            {OP7_LU12I_W, 10'b?}: begin
                alu_op  = ALU_LUI;
                imm_sel = IMM_SI20_HI;
            end
            {OP7_PCADDU12I, 10'b?}: imm_sel = IMM_SI20_HI;
            {OP6_JIRL, 11'b?}: begin
                branch  = BR_JIRL;
                imm_sel = IMM_FOUR;
            end
            {OP6_BL, 11'b?}: begin
                branch  = BR_BL;
                imm_sel = IMM_FOUR;
            end
            {OP6_B, 11'b?}:    branch = BR_B;
            {OP6_BEQ, 11'b?}:  branch = BR_BEQ;
            {OP6_BNE, 11'b?}:  branch = BR_BNE;
            {OP6_BLT, 11'b?}:  branch = BR_BLT;
            {OP6_BGE, 11'b?}:  branch = BR_BGE;
            {OP6_BLTU, 11'b?}: branch = BR_BLTU;
            {OP6_BGEU, 11'b?}: branch = BR_BGEU;
            default:           known = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_sel)
            IMM_FOUR:    imm = 32'd4;
            IMM_SI20_HI: imm = {i20, 12'b0};
            IMM_UI5:     imm = {27'b0, rk};
            IMM_UI12:    imm = {20'b0, i12};
            default:     imm = {{20{i12[11]}}, i12};
        endcase
    end

    assign reg_reg  = known && (i_inst[31:OP10_LSB] == OP10_3R);
    assign is_store = mem_op inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
    assign is_cond  = branch inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    assign o_dec.alu_op      = alu_op;
    assign o_dec.mem_op      = mem_op;
    assign o_dec.branch      = branch;
    assign o_dec.imm_sel     = imm_sel;
    assign o_dec.imm         = imm;
    assign o_dec.br_offs     = (branch inside {BR_B, BR_BL}) ? {{4{i26[25]}}, i26, 2'b0} :
                                                             {{14{i16[15]}}, i16, 2'b0};
    assign o_dec.rj          = rj;
    // stores and compares read rd as the second source
    assign o_dec.rkd         = (is_store || is_cond) ? rd : rk;
    assign o_dec.need_r1     = known && !(branch inside {BR_B, BR_BL}) && (imm_sel != IMM_SI20_HI);
    assign o_dec.need_r2     = reg_reg || is_store || is_cond;
    // link address for jirl/bl, pc base for pcaddu12i
    assign o_dec.src1_is_pc  = (branch inside {BR_JIRL, BR_BL}) ||
                               (imm_sel == IMM_SI20_HI && alu_op == ALU_ADD);
    assign o_dec.src2_is_imm = !reg_reg;
    assign o_dec.rf_we       = known && !is_store && !is_cond && (branch != BR_B);
    assign o_dec.rf_waddr    = (branch == BR_BL) ? reg_addr_t'(1) : rd;

endmodule

//--- design/id_operand_fetch.sv
`timescale 1ns/10ps

module id_operand_fetch
    import id_pkg::*;
(
    input  logic       clk,
    input  reg_addr_t  i_rj,
    input  reg_addr_t  i_rkd,
    input  logic       i_need_r1,
    input  logic       i_need_r2,
    input  ex_bypass_t i_ex_bypass,
    input  rf_bypass_t i_mem_bypass,
    input  rf_bypass_t i_wb_bypass,
    output word_t      o_rj_value,
    output word_t      o_rkd_value,
    output logic       o_stall
);

    word_t rf [NREG];

    function automatic logic hit(rf_bypass_t bp, reg_addr_t addr);
        return bp.we && (bp.waddr == addr) && (addr != '0);
    endfunction

    // youngest producer wins
    function automatic word_t forward(reg_addr_t addr, word_t file_q, ex_bypass_t ex,
                                      rf_bypass_t mem, rf_bypass_t wb);
        word_t value;
        value = (addr == '0) ? '0 : file_q;
        if (hit(wb, addr)) begin
            value = wb.wdata;
        end
        if (hit(mem, addr)) begin
            value = mem.wdata;
        end
        if (hit(ex.rf, addr)) begin
            value = ex.rf.wdata;
        end
        return value;
    endfunction

    // r0 is never written
    always_ff @(posedge clk) begin
        if (i_wb_bypass.we && i_wb_bypass.waddr != '0) begin
            rf[i_wb_bypass.waddr] <= i_wb_bypass.wdata;
        end
    end

    assign o_rj_value  = forward(i_rj, rf[i_rj], i_ex_bypass, i_mem_bypass, i_wb_bypass);
    assign o_rkd_value = forward(i_rkd, rf[i_rkd], i_ex_bypass, i_mem_bypass, i_wb_bypass);

    // load data not ready until MEM
    assign o_stall = i_ex_bypass.is_load &&
                     ((i_need_r1 && hit(i_ex_bypass.rf, i_rj)) ||
                      (i_need_r2 && hit(i_ex_bypass.rf, i_rkd)));

    stall_not_r0: assert property (@(posedge clk)
        o_stall |-> (i_ex_bypass.rf.waddr != '0) &&
                    ((i_need_r1 && i_rj != '0) || (i_need_r2 && i_rkd != '0)));

endmodule

//--- design/id_branch_issue.sv
`timescale 1ns/10ps

module id_branch_issue
    import id_pkg::*;
(
    input  logic      i_valid,
    input  logic      i_stall,
    input  word_t     i_pc,
    input  decode_t   i_dec,
    input  word_t     i_rj_value,
    input  word_t     i_rkd_value,
    output logic      o_br_taken,
    output word_t     o_br_target,
    output id_to_ex_t o_issue
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (i_rj_value == i_rkd_value);
    assign lt_s = ($signed(i_rj_value) < $signed(i_rkd_value));
    assign lt_u = (i_rj_value < i_rkd_value);

    always_comb begin
        case (i_dec.branch)
            BR_BEQ:                cond = eq;
            BR_BNE:                cond = !eq;
            BR_BLT:                cond = lt_s;
            BR_BGE:                cond = !lt_s;
            BR_BLTU:               cond = lt_u;
            BR_BGEU:               cond = !lt_u;
            BR_B, BR_BL, BR_JIRL:  cond = 1'b1;
            default:               cond = 1'b0;
        endcase
    end

    assign o_br_taken  = i_valid && !i_stall && cond;
    // jirl is register relative, the rest pc relative
    assign o_br_target = ((i_dec.branch == BR_JIRL) ? i_rj_value : i_pc) + i_dec.br_offs;

    assign o_issue.alu_op     = i_dec.alu_op;
    assign o_issue.alu_src1   = i_dec.src1_is_pc ? i_pc : i_rj_value;
    assign o_issue.alu_src2   = i_dec.src2_is_imm ? i_dec.imm : i_rkd_value;
    assign o_issue.rf_we      = i_dec.rf_we;
    assign o_issue.rf_waddr   = i_dec.rf_waddr;
    assign o_issue.pc         = i_pc;
    assign o_issue.mem_op     = i_dec.mem_op;
    assign o_issue.store_data = i_rkd_value;

    taken_not_stalled: assert final (!(o_br_taken && i_stall));

endmodule

//--- design/id_stage.sv
`timescale 1ns/10ps

module id_stage
    import id_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       i_if_to_id_valid,
    input  if_to_id_t  i_if_to_id,
    input  logic       i_ex_allowin,
    input  ex_bypass_t i_ex_bypass,
    input  rf_bypass_t i_mem_bypass,
    input  rf_bypass_t i_wb_bypass,
    output logic       o_id_allowin,
    output logic       o_id_to_ex_valid,
    output id_to_ex_t  o_id_to_ex,
    output logic       o_br_taken,
    output word_t      o_br_target
);

    logic      id_valid;
    if_to_id_t if_to_id_q;
    decode_t   dec;
    word_t     rj_value;
    word_t     rkd_value;
    logic      stall;

    assign o_id_allowin     = !id_valid || (!stall && i_ex_allowin);
    assign o_id_to_ex_valid = id_valid && !stall;

    // a taken branch flushes whatever fetch offers this cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (o_br_taken) begin
            id_valid <= 1'b0;
        end else if (o_id_allowin) begin
            id_valid <= i_if_to_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_if_to_id_valid && o_id_allowin) begin
            if_to_id_q <= i_if_to_id;
        end
    end

    id_decoder u_decoder (
        .i_inst (if_to_id_q.inst),
        .o_dec  (dec)
    );

    id_operand_fetch u_operand_fetch (
        .clk          (clk),
        .i_rj         (dec.rj),
        .i_rkd        (dec.rkd),
        .i_need_r1    (dec.need_r1),
        .i_need_r2    (dec.need_r2),
        .i_ex_bypass  (i_ex_bypass),
        .i_mem_bypass (i_mem_bypass),
        .i_wb_bypass  (i_wb_bypass),
        .o_rj_value   (rj_value),
        .o_rkd_value  (rkd_value),
        .o_stall      (stall)
    );

    id_branch_issue u_branch_issue (
        .i_valid     (id_valid),
        .i_stall     (stall),
        .i_pc        (if_to_id_q.pc),
        .i_dec       (dec),
        .i_rj_value  (rj_value),
        .i_rkd_value (rkd_value),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target),
        .o_issue     (o_id_to_ex)
    );

    issue_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        o_id_to_ex_valid |-> id_valid);

endmodule

//--- include/id_isa_encode.svh
`ifndef ID_ISA_ENCODE_SVH
`define ID_ISA_ENCODE_SVH

// reg-reg form, also the shift-immediate form with ui5 in the rk slot
function automatic word_t enc_3r(logic [16:0] op, reg_addr_t rk, reg_addr_t rj,
                                 reg_addr_t rd);
    return {op, rk, rj, rd};
endfunction

function automatic word_t enc_2ri12(logic [9:0] op, logic [11:0] i12, reg_addr_t rj,
                                    reg_addr_t rd);
    return {op, i12, rj, rd};
endfunction

function automatic word_t enc_1ri20(logic [6:0] op, logic [19:0] i20, reg_addr_t rd);
    return {op, i20, rd};
endfunction

function automatic word_t enc_2ri16(logic [5:0] op, logic [15:0] i16, reg_addr_t rj,
                                    reg_addr_t rd);
    return {op, i16, rj, rd};
endfunction

// b and bl split the offset around the low slots
function automatic word_t enc_i26(logic [5:0] op, logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

// expected src2 of the 12-bit immediate forms
function automatic word_t exp_imm12(logic [9:0] op, logic [11:0] i12);
    if (op inside {OP10_ANDI, OP10_ORI, OP10_XORI}) begin
        return {20'b0, i12};
    end
    return {{20{i12[11]}}, i12};
endfunction

function automatic word_t exp_target16(word_t base, logic [15:0] i16);
    return base + {{14{i16[15]}}, i16, 2'b0};
endfunction

function automatic word_t exp_target26(word_t pc, logic [25:0] offs);
    return pc + {{4{offs[25]}}, offs, 2'b0};
endfunction

`endif

//--- dv/id_stage_tb.sv
`timescale 1ns/10ps

module id_stage_tb
    import id_pkg::*;
;

    `include "id_isa_encode.svh"

    localparam int N_TESTS  = 40;
    localparam int TIMEOUT  = (4 + NREG + N_TESTS * 8) * 100 + 2000;

    logic clk;
    logic resetn;
    logic i_if_to_id_valid;
    if_to_id_t i_if_to_id;
    logic i_ex_allowin;
    ex_bypass_t i_ex_bypass;
    rf_bypass_t i_mem_bypass;
    rf_bypass_t i_wb_bypass;
    logic o_id_allowin;
    logic o_id_to_ex_valid;
    id_to_ex_t o_id_to_ex;
    logic o_br_taken;
    word_t o_br_target;

    word_t rf_m [NREG];
    ex_bypass_t nxt_ex;
    rf_bypass_t nxt_mem;
    rf_bypass_t nxt_wb;
    int errors;
    string test_name;

    // check strobes and expected values
    logic chk, chk_alu, chk_src1, chk_empty, chk_stall, chk_hold, chk_reset;
    alu_op_e exp_op;
    mem_op_e exp_mem;
    word_t exp_src1, exp_src2, exp_store, exp_target;
    word_t exp_pc;
    logic exp_we, exp_taken;
    reg_addr_t exp_waddr;

    id_stage DUT (
        .clk              (clk),
        .resetn           (resetn),
        .i_if_to_id_valid (i_if_to_id_valid),
        .i_if_to_id       (i_if_to_id),
        .i_ex_allowin     (i_ex_allowin),
        .i_ex_bypass      (i_ex_bypass),
        .i_mem_bypass     (i_mem_bypass),
        .i_wb_bypass      (i_wb_bypass),
        .o_id_allowin     (o_id_allowin),
        .o_id_to_ex_valid (o_id_to_ex_valid),
        .o_id_to_ex       (o_id_to_ex),
        .o_br_taken       (o_br_taken),
        .o_br_target      (o_br_target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    a_reset: assert property (@(posedge clk) chk_reset |->
        !o_id_to_ex_valid && !o_br_taken && o_id_allowin)
        else begin
            errors++;
            $display("outputs not in reset state after reset");
        end
    a_valid: assert property (@(posedge clk) chk |-> o_id_to_ex_valid)
        else begin
            errors++;
            $display("error %s: expected valid 1 actual 0", test_name);
        end
    a_op: assert property (@(posedge clk) chk && chk_alu |-> o_id_to_ex.alu_op == exp_op)
        else begin
            errors++;
            $display("error %s: alu_op expected %0d actual %0d", test_name,
                     $sampled(exp_op), $sampled(o_id_to_ex.alu_op));
        end
    a_src1: assert property (@(posedge clk) chk && chk_src1 |-> o_id_to_ex.alu_src1 == exp_src1)
        else begin
            errors++;
            $display("error %s: src1 expected %h actual %h", test_name,
                     $sampled(exp_src1), $sampled(o_id_to_ex.alu_src1));
        end
    a_src2: assert property (@(posedge clk) chk && chk_alu |-> o_id_to_ex.alu_src2 == exp_src2)
        else begin
            errors++;
            $display("error %s: src2 expected %h actual %h", test_name,
                     $sampled(exp_src2), $sampled(o_id_to_ex.alu_src2));
        end
    a_wb: assert property (@(posedge clk) chk && chk_alu |->
        o_id_to_ex.rf_we == exp_we && (!exp_we || o_id_to_ex.rf_waddr == exp_waddr))
        else begin
            errors++;
            $display("error %s: we/waddr expected %b/%0d actual %b/%0d", test_name,
                     $sampled(exp_we), $sampled(exp_waddr),
                     $sampled(o_id_to_ex.rf_we), $sampled(o_id_to_ex.rf_waddr));
        end
    a_mem: assert property (@(posedge clk) chk && chk_alu |-> o_id_to_ex.mem_op == exp_mem)
        else begin
            errors++;
            $display("error %s: mem_op expected %0d actual %0d", test_name,
                     $sampled(exp_mem), $sampled(o_id_to_ex.mem_op));
        end
    a_pc: assert property (@(posedge clk) chk |-> o_id_to_ex.pc == exp_pc)
        else begin
            errors++;
            $display("error %s: pc expected %h actual %h", test_name,
                     $sampled(exp_pc), $sampled(o_id_to_ex.pc));
        end
    a_store: assert property (@(posedge clk) chk && exp_mem == MEM_ST_W |->
        o_id_to_ex.store_data == exp_store)
        else begin
            errors++;
            $display("error %s: store data expected %h actual %h", test_name,
                     $sampled(exp_store), $sampled(o_id_to_ex.store_data));
        end
    a_taken: assert property (@(posedge clk) chk |-> o_br_taken == exp_taken)
        else begin
            errors++;
            $display("error %s: taken expected %b actual %b", test_name,
                     $sampled(exp_taken), $sampled(o_br_taken));
        end
    a_target: assert property (@(posedge clk) chk && exp_taken |-> o_br_target == exp_target)
        else begin
            errors++;
            $display("error %s: target expected %h actual %h", test_name,
                     $sampled(exp_target), $sampled(o_br_target));
        end
    a_empty: assert property (@(posedge clk) chk_empty |-> !o_id_to_ex_valid && o_id_allowin)
        else begin
            errors++;
            $display("%s: stage did not empty after the instruction left", test_name);
        end
    a_stall: assert property (@(posedge clk) chk_stall |-> !o_id_to_ex_valid && !o_id_allowin)
        else begin
            errors++;
            $display("%s: load-use stall did not hold the stage", test_name);
        end
    a_hold: assert property (@(posedge clk) chk_hold |->
        o_id_to_ex_valid && !o_id_allowin && o_id_to_ex == $past(o_id_to_ex))
        else begin
            errors++;
            $display("%s: packet not held stable under back-pressure", test_name);
        end

    task automatic expect_alu(string name, alu_op_e op, word_t s1, word_t s2, logic we,
                              reg_addr_t waddr);
        test_name = name;
        exp_op    = op;
        exp_src1  = s1;
        exp_src2  = s2;
        exp_we    = we;
        exp_waddr = waddr;
        exp_mem   = MEM_NONE;
        exp_taken = 1'b0;
        chk_alu   = 1'b1;
        chk_src1  = 1'b1;
    endtask

    // offer one instruction, check it one cycle after it is accepted
    task automatic issue_inst(word_t inst, word_t pc);
        exp_pc = pc;
        @(posedge clk);
        i_if_to_id_valid <= 1'b1;
        i_if_to_id       <= {inst, pc};
        @(posedge clk);
        // fetch keeps offering the wrong path behind a taken branch
        i_if_to_id_valid <= exp_taken;
        i_ex_bypass      <= nxt_ex;
        i_mem_bypass     <= nxt_mem;
        i_wb_bypass      <= nxt_wb;
        chk              <= 1'b1;
        @(posedge clk);
        i_if_to_id_valid <= 1'b0;
        chk          <= 1'b0;
        chk_empty    <= 1'b1;
        i_ex_bypass  <= '0;
        i_mem_bypass <= '0;
        i_wb_bypass  <= '0;
        @(posedge clk);
        chk_empty <= 1'b0;
        nxt_ex  = '0;
        nxt_mem = '0;
        nxt_wb  = '0;
    endtask

    task automatic write_regs();
        for (int r = 1; r < NREG; r++) begin
            @(posedge clk);
            rf_m[r] = $urandom;
            i_wb_bypass <= '{we: 1'b1, waddr: reg_addr_t'(r), wdata: rf_m[r]};
        end
        @(posedge clk);
        i_wb_bypass <= '0;
    endtask

    task automatic run_branches();
        logic [5:0] ops [6];
        logic [15:0] off;
        word_t a;
        word_t b;
        logic t;
        ops = '{OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU};
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < 2; s++) begin
                off = $urandom;
                a   = rf_m[10];
                b   = rf_m[s ? 10 : 11];
                case (k)
                    0: t = (a == b);
                    1: t = (a != b);
                    2: t = ($signed(a) < $signed(b));
                    3: t = !($signed(a) < $signed(b));
                    4: t = (a < b);
                    default: t = !(a < b);
                endcase
                test_name  = $sformatf("branch_%0d_%0d", k, s);
                chk_alu    = 1'b0;
                chk_src1   = 1'b0;
                exp_taken  = t;
                exp_target = exp_target16(32'h1c00_0400, off);
                issue_inst(enc_2ri16(ops[k], off, 5'd10, s ? 5'd10 : 5'd11), 32'h1c00_0400);
            end
        end
    endtask

    initial begin
        logic [11:0] i12;
        logic [19:0] i20;
        logic [15:0] i16;
        logic [25:0] i26;
        word_t x;
        void'($urandom(32'h3501));
        errors = 0;
        resetn = 1'b0;
        i_if_to_id_valid = 1'b0;
        i_if_to_id = '0;
        i_ex_allowin = 1'b1;
        i_ex_bypass = '0;
        i_mem_bypass = '0;
        i_wb_bypass = '0;
        {chk, chk_alu, chk_src1, chk_empty, chk_stall, chk_hold, chk_reset} = '0;
        nxt_ex = '0;
        nxt_mem = '0;
        nxt_wb = '0;
        rf_m[0] = '0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        chk_reset <= 1'b1;
        @(posedge clk);
        chk_reset <= 1'b0;
        write_regs();

        expect_alu("add_w", ALU_ADD, rf_m[1], rf_m[2], 1'b1, 5'd3);
        issue_inst(enc_3r(OP17_ADD_W, 5'd2, 5'd1, 5'd3), 32'h1c00_0000);
        expect_alu("sub_w", ALU_SUB, rf_m[4], rf_m[5], 1'b1, 5'd6);
        issue_inst(enc_3r(OP17_SUB_W, 5'd5, 5'd4, 5'd6), 32'h1c00_0004);
        expect_alu("sltu", ALU_SLTU, rf_m[7], rf_m[8], 1'b1, 5'd9);
        issue_inst(enc_3r(OP17_SLTU, 5'd8, 5'd7, 5'd9), 32'h1c00_0008);
        expect_alu("srai_w", ALU_SRA, rf_m[12], 32'd17, 1'b1, 5'd13);
        issue_inst(enc_3r(OP17_SRAI_W, 5'd17, 5'd12, 5'd13), 32'h1c00_000c);
        i12 = $urandom;
        expect_alu("addi_w", ALU_ADD, rf_m[14], exp_imm12(OP10_ADDI_W, i12), 1'b1, 5'd15);
        issue_inst(enc_2ri12(OP10_ADDI_W, i12, 5'd14, 5'd15), 32'h1c00_0010);
        i12 = 12'h9a5;
        expect_alu("andi", ALU_AND, rf_m[16], exp_imm12(OP10_ANDI, i12), 1'b1, 5'd17);
        issue_inst(enc_2ri12(OP10_ANDI, i12, 5'd16, 5'd17), 32'h1c00_0014);
        i20 = $urandom;
        expect_alu("lu12i_w", ALU_LUI, '0, {i20, 12'b0}, 1'b1, 5'd18);
        chk_src1 = 1'b0;
        issue_inst(enc_1ri20(OP7_LU12I_W, i20, 5'd18), 32'h1c00_0018);
        expect_alu("pcaddu12i", ALU_ADD, 32'h1c00_001c, {i20, 12'b0}, 1'b1, 5'd19);
        issue_inst(enc_1ri20(OP7_PCADDU12I, i20, 5'd19), 32'h1c00_001c);
        i16 = $urandom;
        expect_alu("jirl", ALU_ADD, 32'h1c00_0020, 32'd4, 1'b1, 5'd20);
        exp_taken  = 1'b1;
        exp_target = exp_target16(rf_m[21], i16);
        issue_inst(enc_2ri16(OP6_JIRL, i16, 5'd21, 5'd20), 32'h1c00_0020);
        i26 = $urandom;
        expect_alu("bl", ALU_ADD, 32'h1c00_0100, 32'd4, 1'b1, 5'd1);
        exp_taken  = 1'b1;
        exp_target = exp_target26(32'h1c00_0100, i26);
        issue_inst(enc_i26(OP6_BL, i26), 32'h1c00_0100);
        i12 = $urandom;
        expect_alu("ld_w", ALU_ADD, rf_m[22], exp_imm12(OP10_LD_W, i12), 1'b1, 5'd23);
        exp_mem = MEM_LD_W;
        issue_inst(enc_2ri12(OP10_LD_W, i12, 5'd22, 5'd23), 32'h1c00_0104);

        // forwarding priority on rj = r5
        nxt_ex  = '{is_load: 1'b0, rf: '{we: 1'b1, waddr: 5'd5, wdata: 32'haaaa_0001}};
        nxt_mem = '{we: 1'b1, waddr: 5'd5, wdata: 32'hbbbb_0002};
        nxt_wb  = '{we: 1'b1, waddr: 5'd5, wdata: 32'hcccc_0003};
        expect_alu("fwd_ex", ALU_ADD, 32'haaaa_0001, rf_m[6], 1'b1, 5'd24);
        issue_inst(enc_3r(OP17_ADD_W, 5'd6, 5'd5, 5'd24), 32'h1c00_0200);
        nxt_mem = '{we: 1'b1, waddr: 5'd5, wdata: 32'hbbbb_0002};
        nxt_wb  = '{we: 1'b1, waddr: 5'd5, wdata: 32'hcccc_0003};
        expect_alu("fwd_mem", ALU_ADD, 32'hbbbb_0002, rf_m[6], 1'b1, 5'd24);
        issue_inst(enc_3r(OP17_ADD_W, 5'd6, 5'd5, 5'd24), 32'h1c00_0204);
        nxt_wb  = '{we: 1'b1, waddr: 5'd5, wdata: 32'hcccc_0004};
        expect_alu("fwd_wb", ALU_ADD, 32'hcccc_0004, rf_m[6], 1'b1, 5'd24);
        issue_inst(enc_3r(OP17_ADD_W, 5'd6, 5'd5, 5'd24), 32'h1c00_0208);
        rf_m[5] = 32'hcccc_0004;
        nxt_ex  = '{is_load: 1'b0, rf: '{we: 1'b1, waddr: 5'd0, wdata: 32'hdead_0005}};
        nxt_mem = '{we: 1'b1, waddr: 5'd0, wdata: 32'hdead_0006};
        expect_alu("fwd_r0", ALU_ADD, '0, rf_m[6], 1'b1, 5'd24);
        issue_inst(enc_3r(OP17_ADD_W, 5'd6, 5'd0, 5'd24), 32'h1c00_020c);

        // load-use on r7
        x = $urandom;
        test_name = "load_use";
        exp_pc = 32'h1c00_0300;
        @(posedge clk);
        i_if_to_id_valid <= 1'b1;
        i_if_to_id <= {enc_3r(OP17_ADD_W, 5'd2, 5'd7, 5'd25), 32'h1c00_0300};
        i_ex_bypass <= '{is_load: 1'b1, rf: '{we: 1'b1, waddr: 5'd7, wdata: x}};
        @(posedge clk);
        i_if_to_id_valid <= 1'b0;
        chk_stall <= 1'b1;
        repeat (2) @(posedge clk);
        chk_stall <= 1'b0;
        i_ex_bypass <= '{is_load: 1'b0, rf: '{we: 1'b1, waddr: 5'd7, wdata: x}};
        expect_alu("load_use", ALU_ADD, x, rf_m[2], 1'b1, 5'd25);
        chk <= 1'b1;
        @(posedge clk);
        chk <= 1'b0;
        i_ex_bypass <= '0;
        chk_empty <= 1'b1;
        @(posedge clk);
        chk_empty <= 1'b0;

        run_branches();

        // store held under back-pressure
        i12 = $urandom;
        expect_alu("st_w_hold", ALU_ADD, rf_m[9], exp_imm12(OP10_ST_W, i12), 1'b0, 5'd0);
        exp_mem   = MEM_ST_W;
        exp_store = rf_m[8];
        exp_pc    = 32'h1c00_0500;
        @(posedge clk);
        i_if_to_id_valid <= 1'b1;
        i_if_to_id <= {enc_2ri12(OP10_ST_W, i12, 5'd9, 5'd8), 32'h1c00_0500};
        i_ex_allowin <= 1'b0;
        @(posedge clk);
        // fetch offers the next instruction while EX is blocked
        i_if_to_id <= {enc_3r(OP17_ADD_W, 5'd2, 5'd1, 5'd3), 32'h1c00_0504};
        chk <= 1'b1;
        @(posedge clk);
        chk <= 1'b0;
        chk_hold <= 1'b1;
        repeat (2) @(posedge clk);
        chk_hold <= 1'b0;
        i_if_to_id_valid <= 1'b0;
        i_ex_allowin <= 1'b1;
        @(posedge clk);
        chk_empty <= 1'b1;
        @(posedge clk);
        chk_empty <= 1'b0;

        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #TIMEOUT;
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
design/id_pkg.sv
design/id_decoder.sv
design/id_operand_fetch.sv
design/id_branch_issue.sv
design/id_stage.sv
dv/id_stage_tb.sv
